// ==== design/RiscvPkg.sv ====
package RiscvPkg;

  typedef logic [5:0] AluCode; // ALU operation select

  // Major opcodes in bits 6:0
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;

  // ALU operation codes
  localparam AluCode aluAnd    = 6'b000000;
  localparam AluCode aluOr     = 6'b000001;
  localparam AluCode aluAdd    = 6'b000010;
  localparam AluCode aluSll    = 6'b000011;
  localparam AluCode aluSrl    = 6'b000100;
  localparam AluCode aluXor    = 6'b000101;
  localparam AluCode aluSub    = 6'b000110;
  localparam AluCode aluSra    = 6'b000111;
  localparam AluCode aluBeq    = 6'b001000;
  localparam AluCode aluBne    = 6'b001001;
  localparam AluCode aluBlt    = 6'b001010;
  localparam AluCode aluBge    = 6'b001011;
  localparam AluCode aluBltu   = 6'b001100;
  localparam AluCode aluBgeu   = 6'b001101;
  localparam AluCode aluMul    = 6'b011000;
  localparam AluCode aluMulh   = 6'b011001;
  localparam AluCode aluMulhsu = 6'b011010;
  localparam AluCode aluMulhu  = 6'b011011;
  localparam AluCode aluDiv    = 6'b011100;
  localparam AluCode aluDivu   = 6'b011101;
  localparam AluCode aluRem    = 6'b011110;
  localparam AluCode aluRemu   = 6'b011111;
  localparam AluCode aluMin    = 6'b100000;
  localparam AluCode aluMax    = 6'b100001;
  localparam AluCode aluMinu   = 6'b100010;
  localparam AluCode aluMaxu   = 6'b100011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } RTypeFields;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ITypeFields;

  typedef struct packed {
    logic [6:0] immHigh;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLow;
    logic [6:0] opcode;
  } STypeFields;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } BTypeFields;

  typedef struct packed {
    logic [19:0] imm31to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } UTypeFields;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } JTypeFields;

  // One fetched word, read through whichever format the opcode calls for
  typedef union packed {
    RTypeFields rType;
    ITypeFields iType;
    STypeFields sType;
    BTypeFields bType;
    UTypeFields uType;
    JTypeFields jType;
  } InstrWord;

endpackage

// ==== design/ImmGen.sv ====
`timescale 1ns/1ps

module ImmGen (
  input  RiscvPkg::InstrWord instr,
  output logic [31:0]        imm
);

  logic       sign;
  logic       isShiftImm;
  logic [6:0] opcode;

  assign sign = instr.iType.imm[11]; // Bit 31 in every format
  assign opcode = instr.rType.opcode;
  assign isShiftImm = (instr.iType.funct3 == 3'b001) || (instr.iType.funct3 == 3'b101);

  always_comb begin
    case (opcode)
      RiscvPkg::opOpImm: begin
        if (isShiftImm) begin
          imm = {27'b0, instr.iType.imm[4:0]}; // shamt only, funct7 dropped
        end else begin
          imm = {{20{sign}}, instr.iType.imm};
        end
      end
      RiscvPkg::opLoad,
      RiscvPkg::opJalr: begin
        imm = {{20{sign}}, instr.iType.imm};
      end
      RiscvPkg::opStore: begin
        imm = {{20{sign}}, instr.sType.immHigh, instr.sType.immLow};
      end
      RiscvPkg::opBranch: begin
        imm = {{19{sign}}, instr.bType.imm12, instr.bType.imm11,
               instr.bType.imm10to5, instr.bType.imm4to1, 1'b0}; // Halfword offset
      end
      RiscvPkg::opLui,
      RiscvPkg::opAuipc: begin
        imm = {instr.uType.imm31to12, 12'b0};
      end
      RiscvPkg::opJal: begin
        imm = {{11{sign}}, instr.jType.imm20, instr.jType.imm19to12,
               instr.jType.imm11, instr.jType.imm10to1, 1'b0};
      end
      default: begin
        imm = 32'b0; // R-type has no immediate
      end
    endcase
  end

endmodule

// ==== design/ExecuteDecoder.sv ====
`timescale 1ns/1ps

module ExecuteDecoder (
  input  RiscvPkg::InstrWord instr,
  output RiscvPkg::AluCode   aluControl,
  output logic               useImm,
  output logic               usePc,
  output logic               isBranch,
  output logic               isJump,
  output logic               jumpReg,
  output logic               writesRd
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign opcode = instr.rType.opcode;
  assign funct7 = instr.rType.funct7;
  assign funct3 = instr.rType.funct3;

  // Base integer ops shared by register and immediate forms
  function automatic RiscvPkg::AluCode baseOp(input logic [2:0] f3, input logic alt);
    RiscvPkg::AluCode code;
    case (f3)
      3'b000:  code = alt ? RiscvPkg::aluSub : RiscvPkg::aluAdd;
      3'b001:  code = RiscvPkg::aluSll;
      3'b010:  code = RiscvPkg::aluBlt;  // slt, inverted in the stage
      3'b011:  code = RiscvPkg::aluBltu; // sltu
      3'b100:  code = RiscvPkg::aluXor;
      3'b101:  code = alt ? RiscvPkg::aluSra : RiscvPkg::aluSrl;
      3'b110:  code = RiscvPkg::aluOr;
      default: code = RiscvPkg::aluAnd;
    endcase
    return code;
  endfunction

  always_comb begin
    aluControl = RiscvPkg::aluAdd;
    useImm = 1'b0;
    usePc = 1'b0;
    isBranch = 1'b0;
    isJump = 1'b0;
    jumpReg = 1'b0;
    writesRd = 1'b0;
    case (opcode)
      RiscvPkg::opOp: begin
        writesRd = 1'b1;
        if (funct7 == 7'd5) begin // Zbb min/max group
          case (funct3)
            3'b100:  aluControl = RiscvPkg::aluMin;
            3'b101:  aluControl = RiscvPkg::aluMinu;
            3'b110:  aluControl = RiscvPkg::aluMax;
            3'b111:  aluControl = RiscvPkg::aluMaxu;
            default: aluControl = RiscvPkg::aluAdd;
          endcase
        end else if (funct7[0]) begin // M extension
          case (funct3)
            3'b000:  aluControl = RiscvPkg::aluMul;
            3'b001:  aluControl = RiscvPkg::aluMulh;
            3'b010:  aluControl = RiscvPkg::aluMulhsu;
            3'b011:  aluControl = RiscvPkg::aluMulhu;
            3'b100:  aluControl = RiscvPkg::aluDiv;
            3'b101:  aluControl = RiscvPkg::aluDivu;
            3'b110:  aluControl = RiscvPkg::aluRem;
            default: aluControl = RiscvPkg::aluRemu;
          endcase
        end else begin
          aluControl = baseOp(funct3, funct7[5]);
        end
      end
      RiscvPkg::opOpImm: begin
        useImm = 1'b1;
        writesRd = 1'b1;
        aluControl = baseOp(funct3, (funct3 == 3'b101) && funct7[5]); // Only srai has alt
      end
      RiscvPkg::opBranch: begin
        isBranch = 1'b1;
        case (funct3)
          3'b000:  aluControl = RiscvPkg::aluBeq;
          3'b001:  aluControl = RiscvPkg::aluBne;
          3'b100:  aluControl = RiscvPkg::aluBlt;
          3'b101:  aluControl = RiscvPkg::aluBge;
          3'b110:  aluControl = RiscvPkg::aluBltu;
          3'b111:  aluControl = RiscvPkg::aluBgeu;
          default: isBranch = 1'b0; // Reserved funct3, never taken
        endcase
      end
      RiscvPkg::opLui: begin
        usePc = 1'b1; // usePc without useImm selects a zero base
        writesRd = 1'b1;
      end
      RiscvPkg::opAuipc: begin
        usePc = 1'b1;
        useImm = 1'b1;
        writesRd = 1'b1;
      end
      RiscvPkg::opJal: begin
        isJump = 1'b1;
        writesRd = 1'b1;
      end
      RiscvPkg::opJalr: begin
        isJump = 1'b1;
        jumpReg = 1'b1;
        useImm = 1'b1;
        writesRd = 1'b1;
      end
      RiscvPkg::opLoad: begin
        useImm = 1'b1; // Address sum only
        writesRd = 1'b1;
      end
      RiscvPkg::opStore: begin
        useImm = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    assert (!(isBranch && writesRd))
      else $error("Branch decoded with a register write");
  end

endmodule

// ==== design/Alu.sv ====
`timescale 1ns/1ps

module Alu (
  input  RiscvPkg::AluCode   aluControl,
  input  logic signed [31:0] operand1,
  input  logic signed [31:0] operand2,
  output logic signed [31:0] resultAlu,
  output logic               zero
);

  logic signed [63:0] productSigned;
  logic signed [64:0] productMixed;
  logic        [63:0] productUnsigned;
  logic        [31:0] operand1U;
  logic        [31:0] operand2U;
  logic        [4:0]  shamt;
  logic               divByZero;
  logic               divOverflow;

  assign operand1U = operand1;
  assign operand2U = operand2;
  assign shamt = operand2U[4:0];

  // Full 64-bit products for the high multiplies
  assign productSigned = operand1 * operand2;
  assign productMixed = operand1 * $signed({1'b0, operand2U}); // rs2 zero-extended
  assign productUnsigned = operand1U * operand2U;

  assign divByZero = (operand2U == 32'b0);
  assign divOverflow = (operand1U == 32'h8000_0000) && (operand2U == 32'hFFFF_FFFF);

  always_comb begin
    case (aluControl)
      RiscvPkg::aluAdd: resultAlu = operand1 + operand2;
      RiscvPkg::aluSub: resultAlu = operand1 - operand2;
      RiscvPkg::aluAnd: resultAlu = operand1 & operand2;
      RiscvPkg::aluOr:  resultAlu = operand1 | operand2;
      RiscvPkg::aluXor: resultAlu = operand1 ^ operand2;
      RiscvPkg::aluSll: resultAlu = operand1 << shamt;
      RiscvPkg::aluSrl: resultAlu = operand1U >> shamt; // Zero fill
      RiscvPkg::aluSra: resultAlu = operand1 >>> shamt; // Sign fill

      // Compares give 0 when the condition holds
      RiscvPkg::aluBeq:  resultAlu = (operand1 == operand2) ? 32'sd0 : 32'sd1;
      RiscvPkg::aluBne:  resultAlu = (operand1 != operand2) ? 32'sd0 : 32'sd1;
      RiscvPkg::aluBlt:  resultAlu = (operand1 < operand2) ? 32'sd0 : 32'sd1;
      RiscvPkg::aluBge:  resultAlu = (operand1 >= operand2) ? 32'sd0 : 32'sd1;
      RiscvPkg::aluBltu: resultAlu = (operand1U < operand2U) ? 32'sd0 : 32'sd1;
      RiscvPkg::aluBgeu: resultAlu = (operand1U >= operand2U) ? 32'sd0 : 32'sd1;

      RiscvPkg::aluMul:    resultAlu = productSigned[31:0];
      RiscvPkg::aluMulh:   resultAlu = productSigned[63:32];
      RiscvPkg::aluMulhsu: resultAlu = productMixed[63:32];
      RiscvPkg::aluMulhu:  resultAlu = productUnsigned[63:32];

      RiscvPkg::aluDiv: begin
        if (divByZero) begin
          resultAlu = '1;
        end else if (divOverflow) begin
          resultAlu = operand1; // Most negative stays
        end else begin
          resultAlu = operand1 / operand2; // Truncates toward zero
        end
      end
      RiscvPkg::aluDivu: begin
        if (divByZero) begin
          resultAlu = '1;
        end else begin
          resultAlu = operand1U / operand2U;
        end
      end
      RiscvPkg::aluRem: begin
        if (divByZero) begin
          resultAlu = operand1;
        end else if (divOverflow) begin
          resultAlu = 32'sd0;
        end else begin
          resultAlu = operand1 % operand2; // Sign follows dividend
        end
      end
      RiscvPkg::aluRemu: begin
        if (divByZero) begin
          resultAlu = operand1;
        end else begin
          resultAlu = operand1U % operand2U;
        end
      end

      RiscvPkg::aluMin:  resultAlu = (operand1 < operand2) ? operand1 : operand2;
      RiscvPkg::aluMax:  resultAlu = (operand1 > operand2) ? operand1 : operand2;
      RiscvPkg::aluMinu: resultAlu = (operand1U < operand2U) ? operand1 : operand2;
      RiscvPkg::aluMaxu: resultAlu = (operand1U > operand2U) ? operand1 : operand2;

      default: resultAlu = operand1 + operand2;
    endcase

    zero = (resultAlu == 32'sd0);
  end

  always_comb begin
    assert (zero == (resultAlu == 32'sd0))
      else $error("ALU zero flag disagrees with result");
  end

endmodule

// ==== design/ExecuteStage.sv ====
`timescale 1ns/1ps

module ExecuteStage (
  input  logic             clock,
  input  logic             reset,
  input  logic             inValid,
  input  logic [31:0]      pc,
  input  logic [31:0]      rs1Data,
  input  logic [31:0]      rs2Data,
  input  logic [31:0]      imm,
  input  logic [4:0]       rdAddr,
  input  RiscvPkg::AluCode aluControl,
  input  logic             useImm,
  input  logic             usePc,
  input  logic             isBranch,
  input  logic             isJump,
  input  logic             jumpReg,
  input  logic             writesRd,
  output logic             outValid,
  output logic [31:0]      result,
  output logic [4:0]       rdAddrOut,
  output logic             rdWrite,
  output logic             branchTaken,
  output logic [31:0]      branchTarget
);

  logic signed [31:0] operand1;
  logic signed [31:0] operand2;
  logic signed [31:0] resultAlu;
  logic               zero;
  logic        [31:0] targetBase;
  logic        [31:0] targetSum;
  logic        [31:0] targetNext;
  logic        [31:0] resultNext;
  logic               takenNext;
  logic               isSetLess;

  // auipc takes pc, lui a zero base
  assign operand1 = !usePc ? rs1Data : (useImm ? pc : 32'd0);
  assign operand2 = (useImm || usePc) ? imm : rs2Data;

  Alu u_alu (
    .aluControl(aluControl),
    .operand1  (operand1),
    .operand2  (operand2),
    .resultAlu (resultAlu),
    .zero      (zero)
  );

  assign targetBase = jumpReg ? rs1Data : pc;
  assign targetSum = targetBase + imm;
  assign targetNext = jumpReg ? {targetSum[31:1], 1'b0} : targetSum; // jalr clears bit 0

  assign takenNext = isJump || (isBranch && zero);

  // slt and sltu reuse the compare codes, whose zero flag is the answer
  assign isSetLess = !isBranch &&
                     ((aluControl == RiscvPkg::aluBlt) || (aluControl == RiscvPkg::aluBltu));

  always_comb begin
    if (isJump) begin
      resultNext = pc + 32'd4; // Link address
    end else if (isSetLess) begin
      resultNext = {31'b0, zero};
    end else begin
      resultNext = resultAlu;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
      rdWrite <= 1'b0;
      branchTaken <= 1'b0;
    end else begin
      outValid <= inValid;
      rdWrite <= inValid && writesRd && (rdAddr != 5'd0); // x0 never written
      branchTaken <= inValid && takenNext;
    end
  end

  always_ff @(posedge clock) begin
    if (inValid) begin // Hold last item otherwise
      result <= resultNext;
      rdAddrOut <= rdAddr;
      branchTarget <= targetNext;
    end
  end

  assert property (@(posedge clock) disable iff (reset) branchTaken |-> outValid)
    else $error("branchTaken without outValid");

  assert property (@(posedge clock) reset |=> !outValid)
    else $error("outValid high right after reset");

endmodule

// ==== design/ExecuteTop.sv ====
`timescale 1ns/1ps

module ExecuteTop (
  input  logic               clock,
  input  logic               reset,
  input  logic               inValid,
  input  RiscvPkg::InstrWord instr,
  input  logic [31:0]        pc,
  input  logic [31:0]        rs1Data,
  input  logic [31:0]        rs2Data,
  output logic               outValid,
  output logic [31:0]        result,
  output logic [4:0]         rdAddr,
  output logic               rdWrite,
  output logic               branchTaken,
  output logic [31:0]        branchTarget
);

  logic [31:0]      imm;
  RiscvPkg::AluCode aluControl;
  logic             useImm;
  logic             usePc;
  logic             isBranch;
  logic             isJump;
  logic             jumpReg;
  logic             writesRd;

  ImmGen u_immGen (
    .instr(instr),
    .imm  (imm)
  );

  ExecuteDecoder u_decoder (
    .instr     (instr),
    .aluControl(aluControl),
    .useImm    (useImm),
    .usePc     (usePc),
    .isBranch  (isBranch),
    .isJump    (isJump),
    .jumpReg   (jumpReg),
    .writesRd  (writesRd)
  );

  ExecuteStage u_stage (
    .clock       (clock),
    .reset       (reset),
    .inValid     (inValid),
    .pc          (pc),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data),
    .imm         (imm),
    .rdAddr      (instr.rType.rd), // Same position in every format
    .aluControl  (aluControl),
    .useImm      (useImm),
    .usePc       (usePc),
    .isBranch    (isBranch),
    .isJump      (isJump),
    .jumpReg     (jumpReg),
    .writesRd    (writesRd),
    .outValid    (outValid),
    .result      (result),
    .rdAddrOut   (rdAddr),
    .rdWrite     (rdWrite),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget)
  );

endmodule

// ==== dv/ExecuteRefModel.svh ====
`ifndef EXECUTE_REF_MODEL_SVH
`define EXECUTE_REF_MODEL_SVH

// Immediate straight from the raw instruction bits
function automatic logic [31:0] immediateOf(input logic [31:0] w);
  case (w[6:0])
    RiscvPkg::opOpImm, RiscvPkg::opLoad, RiscvPkg::opJalr: return {{20{w[31]}}, w[31:20]};
    RiscvPkg::opStore:  return {{20{w[31]}}, w[31:25], w[11:7]};
    RiscvPkg::opBranch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    RiscvPkg::opLui, RiscvPkg::opAuipc: return {w[31:12], 12'b0};
    RiscvPkg::opJal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    default:            return 32'b0;
  endcase
endfunction

function automatic logic branchHolds(input logic [2:0] f3, input logic [31:0] a,
    input logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

// RV32I integer ops, alt selects sub or sra
function automatic logic [31:0] baseResult(input logic [2:0] f3, input logic alt,
    input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return {31'b0, $signed(a) < $signed(b)};
    3'd3:    return {31'b0, a < b};
    3'd4:    return a ^ b;
    3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [31:0] mulDivResult(input logic [2:0] f3, input logic [31:0] a,
    input logic [31:0] b);
  logic [63:0] wide;
  logic        overflow;
  overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
  case (f3)
    3'd0, 3'd1: wide = $signed(a) * $signed(b);
    3'd2:       wide = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
    default:    wide = {32'b0, a} * {32'b0, b};
  endcase
  case (f3)
    3'd0: return wide[31:0];
    3'd4: begin
      if (b == 32'd0) return 32'hFFFF_FFFF;
      if (overflow) return a;
      return $signed(a) / $signed(b);
    end
    3'd5: return (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
    3'd6: begin
      if (b == 32'd0) return a;
      if (overflow) return 32'd0;
      return $signed(a) % $signed(b);
    end
    3'd7: return (b == 32'd0) ? a : a % b;
    default: return wide[63:32]; // mulh, mulhsu, mulhu
  endcase
endfunction

function automatic logic [31:0] expectedResult(input logic [31:0] w, input logic [31:0] pc,
    input logic [31:0] a, input logic [31:0] b);
  logic [31:0] imm;
  imm = immediateOf(w);
  case (w[6:0])
    RiscvPkg::opLui:   return imm;
    RiscvPkg::opAuipc: return pc + imm;
    RiscvPkg::opJal, RiscvPkg::opJalr: return pc + 32'd4;
    RiscvPkg::opLoad, RiscvPkg::opStore: return a + imm;
    RiscvPkg::opBranch: return branchHolds(w[14:12], a, b) ? 32'd0 : 32'd1;
    RiscvPkg::opOpImm: return baseResult(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm);
    RiscvPkg::opOp: begin
      if (w[31:25] == 7'd5) begin
        case (w[14:12])
          3'd4:    return ($signed(a) < $signed(b)) ? a : b;
          3'd5:    return (a < b) ? a : b;
          3'd6:    return ($signed(a) > $signed(b)) ? a : b;
          3'd7:    return (a > b) ? a : b;
          default: return a + b;
        endcase
      end
      if (w[25]) return mulDivResult(w[14:12], a, b);
      return baseResult(w[14:12], w[30], a, b);
    end
    default: return a + b;
  endcase
endfunction

function automatic logic expectedTaken(input logic [31:0] w, input logic [31:0] a,
    input logic [31:0] b);
  if (w[6:0] == RiscvPkg::opJal || w[6:0] == RiscvPkg::opJalr) return 1'b1;
  if (w[6:0] == RiscvPkg::opBranch) return branchHolds(w[14:12], a, b);
  return 1'b0;
endfunction

function automatic logic [31:0] expectedTarget(input logic [31:0] w, input logic [31:0] pc,
    input logic [31:0] a);
  if (w[6:0] == RiscvPkg::opJalr) return (a + immediateOf(w)) & 32'hFFFF_FFFE;
  return pc + immediateOf(w);
endfunction

function automatic logic writesRegister(input logic [31:0] w);
  if (w[11:7] == 5'd0) return 1'b0;
  return w[6:0] inside {RiscvPkg::opOp, RiscvPkg::opOpImm, RiscvPkg::opLui, RiscvPkg::opAuipc,
                        RiscvPkg::opJal, RiscvPkg::opJalr, RiscvPkg::opLoad};
endfunction

function automatic logic isControlFlow(input logic [31:0] w);
  return w[6:0] inside {RiscvPkg::opBranch, RiscvPkg::opJal, RiscvPkg::opJalr};
endfunction

`endif

// ==== dv/ExecuteTb.sv ====
`timescale 1ns/1ps

module ExecuteTb;

  logic               clock;
  logic               reset;
  logic               inValid;
  RiscvPkg::InstrWord instr;
  logic [31:0]        pc;
  logic [31:0]        rs1Data;
  logic [31:0]        rs2Data;
  logic               outValid;
  logic [31:0]        result;
  logic [4:0]         rdAddr;
  logic               rdWrite;
  logic               branchTaken;
  logic [31:0]        branchTarget;

  integer seed = 12;
  int     errorCount = 0;
  int     checkCount = 0;
  int     itemTest;
  logic   started = 1'b0;

  // Expected values, recorded at the input edge
  logic        expValid = 1'b0;
  logic [31:0] expResult;
  logic [31:0] expTarget;
  logic        expTaken;
  logic        expWrite;
  logic        expFlow;
  logic [4:0]  expRd;
  int          expTest;

  // Sign, overflow and zero-divisor corners
  logic [31:0] pairA [6] = '{32'd7, 32'hFFFF_FFF9, 32'h8000_0000, 32'd5, 32'hFFFF_FFFF,
                             32'h7FFF_FFFF};
  logic [31:0] pairB [6] = '{32'd3, 32'd3, 32'hFFFF_FFFF, 32'd0, 32'hFFFF_FFFF,
                             32'h8000_0000};

  `include "ExecuteRefModel.svh"

  ExecuteTop u_dut (
    .clock       (clock),
    .reset       (reset),
    .inValid     (inValid),
    .instr       (instr),
    .pc          (pc),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data),
    .outValid    (outValid),
    .result      (result),
    .rdAddr      (rdAddr),
    .rdWrite     (rdWrite),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period
  end

  always @(posedge clock) begin
    if (expValid) checkCount++;
    started <= 1'b1;
    expValid <= reset ? 1'b0 : inValid;
    if (inValid) begin
      expResult <= expectedResult(instr, pc, rs1Data, rs2Data);
      expTaken <= expectedTaken(instr, rs1Data, rs2Data);
      expTarget <= expectedTarget(instr, pc, rs1Data);
      expWrite <= writesRegister(instr);
      expFlow <= isControlFlow(instr);
      expRd <= instr[11:7];
      expTest <= itemTest;
    end
  end

  function automatic string testName(input int id);
    case (id)
      0:       return "reset";
      1:       return "arith";
      2:       return "mext";
      3:       return "minmax";
      4:       return "branch";
      default: return "random";
    endcase
  endfunction

  task automatic reportMismatch(input string test, input string what,
      input logic [31:0] expected, input logic [31:0] actual);
    $display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
    errorCount++;
  endtask

  // One outValid per strobe, one cycle later
  assert property (@(posedge clock) started |-> outValid == expValid)
    else reportMismatch(testName($sampled(expTest)), "outValid", $sampled(expValid),
                        $sampled(outValid));
  assert property (@(posedge clock) started && !expValid |-> !rdWrite && !branchTaken)
    else reportMismatch("idle", "rdWrite/branchTaken", 0, {$sampled(rdWrite),
                        $sampled(branchTaken)});
  assert property (@(posedge clock) expValid |-> result == expResult)
    else reportMismatch(testName($sampled(expTest)), "result", $sampled(expResult),
                        $sampled(result));
  assert property (@(posedge clock) expValid |-> rdWrite == expWrite)
    else reportMismatch(testName($sampled(expTest)), "rdWrite", $sampled(expWrite),
                        $sampled(rdWrite));
  assert property (@(posedge clock) expValid |-> rdAddr == expRd)
    else reportMismatch(testName($sampled(expTest)), "rdAddr", $sampled(expRd),
                        $sampled(rdAddr));
  assert property (@(posedge clock) expValid |-> branchTaken == expTaken)
    else reportMismatch(testName($sampled(expTest)), "branchTaken", $sampled(expTaken),
                        $sampled(branchTaken));
  assert property (@(posedge clock) expValid && expFlow |-> branchTarget == expTarget)
    else reportMismatch(testName($sampled(expTest)), "branchTarget", $sampled(expTarget),
                        $sampled(branchTarget));

  function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, RiscvPkg::opOp};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [2:0] f3,
      input logic [6:0] op);
    return {imm, 5'd1, f3, 5'd4, op};
  endfunction

  function automatic logic [31:0] branchWord(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], RiscvPkg::opBranch};
  endfunction

  function automatic logic [31:0] jalWord(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, RiscvPkg::opJal};
  endfunction

  task automatic issue(input int test, input logic [31:0] word, input logic [31:0] a,
      input logic [31:0] b);
    @(posedge clock);
    inValid <= 1'b1;
    instr <= word;
    pc <= $random(seed) & 32'hFFFF_FFFC; // Word aligned
    rs1Data <= a;
    rs2Data <= b;
    itemTest <= test;
  endtask

  // Stop strobing and wait for the last result to leave
  task automatic drain;
    int cycles;
    cycles = 0;
    @(posedge clock);
    inValid <= 1'b0;
    do begin
      @(negedge clock);
      cycles++;
    end while ((outValid || expValid) && cycles < 10);
    if (outValid || expValid) begin
      $display("ERROR: outputs still valid %0d cycles after the last strobe", cycles);
      errorCount++;
    end
  endtask

  task automatic randomItems(input int count);
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    for (int i = 0; i < count; i++) begin
      word = $random(seed);
      a = $random(seed);
      b = $random(seed);
      pick = $random(seed);
      case (pick[2:0])
        3'd0: word = {1'b0, word[30], 5'b0, word[24:7], RiscvPkg::opOp};
        3'd1: word = {7'h01, word[24:7], RiscvPkg::opOp};
        3'd2: word = {7'h05, word[24:15], 1'b1, word[13:7], RiscvPkg::opOp}; // funct3 4 to 7
        3'd3: word = {word[31:7], RiscvPkg::opOpImm};
        3'd4: word = {word[31:15], word[14] | word[13], word[13:7], RiscvPkg::opBranch};
        3'd5: word = {word[31:7], pick[3] ? RiscvPkg::opJal : RiscvPkg::opJalr};
        3'd6: word = {word[31:7], pick[3] ? RiscvPkg::opLui : RiscvPkg::opAuipc};
        default: word = {word[31:7], pick[3] ? RiscvPkg::opLoad : RiscvPkg::opStore};
      endcase
      if (pick[7:4] == 4'd0) begin
        word[11:7] = 5'd0; // Aimed at x0
      end
      if (pick[9:8] == 2'd0) begin
        b = b & 32'h3; // Small divisors, zero included
      end
      issue(5, word, a, b);
    end
  endtask

  initial begin
    reset = 1'b1;
    inValid = 1'b0;
    instr = '0;
    pc = 32'd0;
    rs1Data = 32'd0;
    rs2Data = 32'd0;
    itemTest = 0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    repeat (4) @(posedge clock); // Idle, no strobe

    for (int p = 0; p < 6; p++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        issue(1, rTypeWord(7'h00, f3[2:0]), pairA[p], pairB[p]);
        issue(1, rTypeWord(7'h20, f3[2:0]), pairA[p], pairB[p]);
        issue(1, iTypeWord(12'hFFF, f3[2:0], RiscvPkg::opOpImm), pairA[p], pairB[p]);
        issue(1, iTypeWord(12'h41F, f3[2:0], RiscvPkg::opOpImm), pairA[p], pairB[p]);
      end
    end
    issue(1, {20'h8ABCD, 5'd7, RiscvPkg::opLui}, 32'd1, 32'd2);
    issue(1, {20'h00123, 5'd7, RiscvPkg::opAuipc}, 32'd1, 32'd2);
    issue(1, iTypeWord(12'h800, 3'b010, RiscvPkg::opLoad), 32'h0000_1000, 32'd0);
    issue(1, {7'h7F, 5'd2, 5'd1, 3'b010, 5'h1C, RiscvPkg::opStore}, 32'h0000_2000, 32'h55);
    drain();

    for (int p = 0; p < 6; p++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        issue(2, rTypeWord(7'h01, f3[2:0]), pairA[p], pairB[p]);
      end
    end
    drain();

    for (int p = 0; p < 6; p++) begin
      for (int f3 = 4; f3 < 8; f3++) begin
        issue(3, rTypeWord(7'h05, f3[2:0]), pairA[p], pairB[p]);
        issue(3, rTypeWord(7'h05, f3[2:0]), pairB[p], pairA[p]);
      end
    end
    drain();

    for (int p = 0; p < 6; p++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        if (f3 != 2 && f3 != 3) begin
          issue(4, branchWord(f3[2:0], 13'h1FF4), pairA[p], pairB[p]); // Backward
          issue(4, branchWord(f3[2:0], 13'h0FFE), pairB[p], pairA[p]);
        end
      end
    end
    issue(4, jalWord(21'h1FFFF0, 5'd1), 32'd0, 32'd0);
    issue(4, jalWord(21'h000804, 5'd0), 32'd0, 32'd0);
    issue(4, iTypeWord(12'h803, 3'b000, RiscvPkg::opJalr), 32'h0000_1000, 32'd0);
    issue(4, iTypeWord(12'hFFF, 3'b000, RiscvPkg::opJalr), 32'h8000_0000, 32'd0);
    drain();

    randomItems(200);
    drain();

    $display("Checked %0d items, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+dv
design/RiscvPkg.sv
design/ImmGen.sv
design/ExecuteDecoder.sv
design/Alu.sv
design/ExecuteStage.sv
design/ExecuteTop.sv
dv/ExecuteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ExecuteTb \
  -o simExecute > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simExecute 2>&1 | tee sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
